// File: logic/tis_consts.svh
`ifndef TIS_CONSTS_SVH
`define TIS_CONSTS_SVH

// Datapath and program geometry
`define DATA_W      11
`define INSTR_W     16
`define PROG_DEPTH  15
`define PC_W        4

// ACC and the ALU clamp to plus and minus this value
`define SAT_MAX     999

// Operand field codes above the literal range
`define SRC_NIL     11'd1000
`define SRC_ACC     11'd1001
`define SRC_LEFT    11'd1004
`define SRC_RIGHT   11'd1005
`define SRC_UP      11'd1006
`define SRC_DOWN    11'd1007

`endif

// File: logic/tisIsaPkg.sv
`default_nettype none
`include "tis_consts.svh"

package tisIsaPkg;

   typedef enum logic [2:0] {
      dirNil   = 3'd0,
      dirAcc   = 3'd1,
      dirLeft  = 3'd4,   // Low two bits give the port
      dirRight = 3'd5,
      dirUp    = 3'd6,
      dirDown  = 3'd7
   } dirE;

   // Same field as dirE when the class bit is set
   typedef enum logic [2:0] {
      opAdd  = 3'd4,
      opSub  = 3'd5,
      opJro  = 3'd6,
      opMisc = 3'd7
   } opE;

   typedef enum logic [6:0] {
      subJmp  = 7'h7A,
      subJez  = 7'h7B,
      subJnz  = 7'h7C,
      subJgz  = 7'h7D,
      subJlz  = 7'h7E,
      subMisc = 7'h7F
   } subOpE;

   typedef enum logic [3:0] {
      miscSwp = 4'hC,
      miscSav = 4'hD,
      miscNeg = 4'hE,
      miscNop = 4'hF
   } miscE;

   typedef enum logic [1:0] {
      aluAdd,
      aluSub,
      aluNeg
   } aluOpE;

   typedef enum logic [1:0] {
      kindLit,
      kindAcc,
      kindNil,
      kindPort
   } srcKindE;

   typedef struct packed {
      logic                      spare;
      logic                      ctrl;
      dirE                       dst;
      logic signed [`DATA_W-1:0] operand;
   } opViewS;

   typedef struct packed {
      logic             spare;
      logic             ctrl;
      opE               grp;
      subOpE            subOp;
      logic [`PC_W-1:0] target;   // Jump address or misc selector
   } ctlViewS;

   typedef union packed {
      opViewS  op;
      ctlViewS ctl;
   } instrU;

endpackage

`default_nettype wire

// File: logic/tisPortPkg.sv
`default_nettype none
`include "tis_consts.svh"

package tisPortPkg;

   typedef struct packed {
      logic                      ready;
      logic signed [`DATA_W-1:0] data;
   } nbrInS;

   typedef struct packed {
      logic       valid;
      logic [1:0] dir;   // LEFT 0, RIGHT 1, UP 2, DOWN 3
   } opReqS;

   typedef struct packed {
      logic                      valid;
      logic signed [`DATA_W-1:0] data;
   } opRspS;

   typedef struct packed {
      logic                      valid;
      logic [1:0]                dir;
      logic signed [`DATA_W-1:0] data;
   } wrReqS;

endpackage

`default_nettype wire

// File: logic/progMem.sv
`timescale 1ns/1ns
`default_nettype none
`include "tis_consts.svh"

module progMem (
   input  logic              clk,
   input  logic              rst,
   input  logic              progWe,
   input  logic [`PC_W-1:0]  progAddr,
   input  tisIsaPkg::instrU  progData,
   input  logic [`PC_W-1:0]  pc,
   output tisIsaPkg::instrU  instr
);
   import tisIsaPkg::*;

   localparam logic [`INSTR_W-1:0] nopWord = {1'b0, 1'b1, opMisc, subMisc, miscNop};

   instrU mem [`PROG_DEPTH];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `PROG_DEPTH; i++) begin
            mem[i] <= nopWord;
         end
      end else if (progWe) begin
         mem[progAddr] <= progData;
      end
   end

   assign instr = (pc < `PROG_DEPTH) ? mem[pc] : nopWord;   // Slot 15 reads as NOP

   assert property (@(posedge clk) disable iff (rst) progWe |-> (progAddr < `PROG_DEPTH))
      else $error("progMem: load address %0d beyond program depth", progAddr);

endmodule

`default_nettype wire

// File: logic/satAlu.sv
`timescale 1ns/1ns
`default_nettype none
`include "tis_consts.svh"

module satAlu (
   input  tisIsaPkg::aluOpE          op,
   input  logic signed [`DATA_W-1:0] acc,
   input  logic signed [`DATA_W-1:0] operand,
   output logic signed [`DATA_W-1:0] result
);
   import tisIsaPkg::*;

   localparam int wideW = `DATA_W + 1;
   localparam logic signed [wideW-1:0] posLim = wideW'(`SAT_MAX);
   localparam logic signed [wideW-1:0] negLim = wideW'(-`SAT_MAX);

   logic signed [wideW-1:0] accW;
   logic signed [wideW-1:0] oprW;
   logic signed [wideW-1:0] raw;

   assign accW = wideW'(acc);   // Sign extended
   assign oprW = wideW'(operand);

   always_comb begin
      case (op)
         aluSub:  raw = accW - oprW;
         aluNeg:  raw = -accW;   // -1024 turns positive here
         default: raw = accW + oprW;
      endcase
   end

   always_comb begin
      if (raw > posLim) begin
         result = posLim[`DATA_W-1:0];
      end else if (raw < negLim) begin
         result = negLim[`DATA_W-1:0];
      end else begin
         result = raw[`DATA_W-1:0];
      end
   end

endmodule

`default_nettype wire

// File: logic/portUnit.sv
`timescale 1ns/1ns
`default_nettype none
`include "tis_consts.svh"

module portUnit (
   input  logic                      clk,
   input  logic                      rst,
   input  tisPortPkg::nbrInS         nbrIn [4],
   input  tisPortPkg::opReqS         opReq,
   output tisPortPkg::opRspS         opRsp,
   input  tisPortPkg::wrReqS         wrReq,
   output logic                      wrAck,
   output logic [3:0]                read,
   output logic [3:0]                write,
   output logic signed [`DATA_W-1:0] out,
   input  logic [3:0]                wready,
   output logic                      wrBusy
);
   import tisPortPkg::*;

   nbrInS sel;
   logic  take;

   assign sel = nbrIn[opReq.dir];

   // A word under its own read pulse is already consumed
   assign opRsp.valid = sel.ready && !read[opReq.dir];
   assign opRsp.data  = sel.data;
   assign take        = opReq.valid && opRsp.valid;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         read <= '0;
      end else begin
         read <= take ? (4'b0001 << opReq.dir) : 4'b0000;   // One cycle pulse
      end
   end

   assign wrBusy = |write;
   assign wrAck  = |(write & wready);   // Neighbor took the word

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         write <= '0;
         out   <= '0;
      end else if (wrReq.valid) begin
         write <= 4'b0001 << wrReq.dir;
         out   <= wrReq.data;
      end else if (wrAck) begin
         write <= '0;   // Out keeps its last value
      end
   end

   // Back-pressure holds the word and the strobe
   assert property (@(posedge clk) disable iff (rst)
      ((write != '0) && !wrAck) |=> ($stable(write) && $stable(out)))
      else $error("portUnit: write or out changed under back-pressure");

   assert property (@(posedge clk) disable iff (rst)
      (read != '0) |=> ((read & $past(read)) == '0))
      else $error("portUnit: read held high for two cycles %b", read);

endmodule

`default_nettype wire

// File: logic/nodeSequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "tis_consts.svh"

module nodeSequencer (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`PC_W-1:0]          pLength,
   input  tisIsaPkg::instrU          instr,
   output tisPortPkg::opReqS         opReq,
   input  tisPortPkg::opRspS         opRsp,
   output tisPortPkg::wrReqS         wrReq,
   input  logic                      wrBusy,
   input  logic                      wrAck,
   output tisIsaPkg::aluOpE          aluOp,
   output logic signed [`DATA_W-1:0] operand,
   input  logic signed [`DATA_W-1:0] aluResult,
   output logic [`PC_W-1:0]          pc,
   output logic signed [`DATA_W-1:0] acc,
   output logic signed [`DATA_W-1:0] bak
);
   import tisIsaPkg::*;

   localparam int wideW = `DATA_W + 1;

   logic                    run;
   logic                    usesSrc;
   logic                    isWrite;
   logic                    srcOk;
   srcKindE                 kind;
   logic [`PC_W-1:0]        pcLast;
   logic [`PC_W-1:0]        pcNext;
   logic [`PC_W-1:0]        jroTarget;
   logic signed [wideW-1:0] jroSum;
   logic signed [wideW-1:0] lastWide;

   assign run    = pLength != '0;
   assign pcLast = pLength - 1'b1;
   assign pcNext = (pc == pcLast) ? '0 : pc + 1'b1;   // Wrap after last slot

   always_comb begin
      if (instr.op.operand <= `SAT_MAX) begin
         kind = kindLit;
      end else begin
         case (instr.op.operand)
            `SRC_ACC:                                  kind = kindAcc;
            `SRC_LEFT, `SRC_RIGHT, `SRC_UP, `SRC_DOWN: kind = kindPort;
            `SRC_NIL:                                  kind = kindNil;
            default:                                   kind = kindNil;   // Old ANY and LAST
         endcase
      end
   end

   always_comb begin
      case (kind)
         kindLit:  operand = instr.op.operand;
         kindAcc:  operand = acc;
         kindPort: operand = opRsp.data;
         default:  operand = '0;
      endcase
   end

   // MISC group reuses the operand bits as sub-op and target
   assign usesSrc = !instr.op.ctrl || (instr.ctl.grp inside {opAdd, opSub, opJro});
   assign isWrite = !instr.op.ctrl &&
                    (instr.op.dst inside {dirLeft, dirRight, dirUp, dirDown});
   assign srcOk   = !usesSrc || (kind != kindPort) || opRsp.valid;

   assign opReq.valid = run && !wrBusy && usesSrc && (kind == kindPort);
   assign opReq.dir   = instr.op.operand[1:0];

   assign wrReq.valid = run && !wrBusy && isWrite && srcOk;
   assign wrReq.dir   = instr.op.dst[1:0];
   assign wrReq.data  = operand;

   always_comb begin
      case (instr.ctl.grp)
         opSub:   aluOp = aluSub;
         opMisc:  aluOp = aluNeg;
         default: aluOp = aluAdd;
      endcase
   end

   // JRO clamp into 0 .. pLength-1
   assign jroSum   = wideW'(pc) + wideW'(operand);
   assign lastWide = wideW'(pcLast);

   always_comb begin
      if (jroSum < 0) begin
         jroTarget = '0;
      end else if (jroSum > lastWide) begin
         jroTarget = pcLast;
      end else begin
         jroTarget = jroSum[`PC_W-1:0];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pc  <= '0;
         acc <= '0;
         bak <= '0;
      end else if (run) begin
         if (wrBusy) begin
            if (wrAck) begin
               pc <= pcNext;
            end
         end else if (srcOk) begin
            pc <= pcNext;
            if (!instr.op.ctrl) begin
               if (isWrite) begin
                  pc <= pc;   // Held until wready
               end
               if (instr.op.dst == dirAcc) begin
                  acc <= operand;
               end
            end else begin
               case (instr.ctl.grp)
                  opAdd, opSub: acc <= aluResult;
                  opJro:        pc  <= jroTarget;
                  opMisc: begin
                     case (instr.ctl.subOp)
                        subJmp: pc <= instr.ctl.target;
                        subJez: if (acc == '0) pc <= instr.ctl.target;
                        subJnz: if (acc != '0) pc <= instr.ctl.target;
                        subJgz: if (acc > 0) pc <= instr.ctl.target;
                        subJlz: if (acc < 0) pc <= instr.ctl.target;
                        subMisc: begin
                           case (instr.ctl.target)
                              miscSwp: begin
                                 acc <= bak;
                                 bak <= acc;
                              end
                              miscSav: bak <= acc;
                              miscNeg: acc <= aluResult;
                              default: ;   // NOP
                           endcase
                        end
                        default: ;
                     endcase
                  end
                  default: ;   // Unused classes run as NOP
               endcase
            end
         end
      end
   end

   assert property (@(posedge clk) disable iff (rst) (pLength != '0) |-> (pc < pLength))
      else $error("nodeSequencer: pc %0d outside program of length %0d", pc, pLength);

endmodule

`default_nettype wire

// File: logic/tisNode.sv
`timescale 1ns/1ns
`default_nettype none
`include "tis_consts.svh"

module tisNode (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      progWe,
   input  logic [`PC_W-1:0]          progAddr,
   input  tisIsaPkg::instrU          progData,
   input  logic [`PC_W-1:0]          pLength,
   input  tisPortPkg::nbrInS         nbrIn [4],
   input  logic [3:0]                wready,
   output logic [3:0]                read,
   output logic [3:0]                write,
   output logic signed [`DATA_W-1:0] out,
   output logic [`PC_W-1:0]          pc,
   output logic signed [`DATA_W-1:0] acc,
   output logic signed [`DATA_W-1:0] bak
);
   import tisIsaPkg::*;
   import tisPortPkg::*;

   instrU                     instr;
   opReqS                     opReq;
   opRspS                     opRsp;
   wrReqS                     wrReq;
   logic                      wrBusy;
   logic                      wrAck;
   aluOpE                     aluOp;
   logic signed [`DATA_W-1:0] operand;
   logic signed [`DATA_W-1:0] aluResult;

   progMem uMem (
      .clk      (clk),
      .rst      (rst),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .pc       (pc),
      .instr    (instr)
   );

   nodeSequencer uSeq (
      .clk       (clk),
      .rst       (rst),
      .pLength   (pLength),
      .instr     (instr),
      .opReq     (opReq),
      .opRsp     (opRsp),
      .wrReq     (wrReq),
      .wrBusy    (wrBusy),
      .wrAck     (wrAck),
      .aluOp     (aluOp),
      .operand   (operand),
      .aluResult (aluResult),
      .pc        (pc),
      .acc       (acc),
      .bak       (bak)
   );

   portUnit uPorts (
      .clk    (clk),
      .rst    (rst),
      .nbrIn  (nbrIn),
      .opReq  (opReq),
      .opRsp  (opRsp),
      .wrReq  (wrReq),
      .wrAck  (wrAck),
      .read   (read),
      .write  (write),
      .out    (out),
      .wready (wready),
      .wrBusy (wrBusy)
   );

   satAlu uAlu (
      .op      (aluOp),
      .acc     (acc),
      .operand (operand),
      .result  (aluResult)
   );

endmodule

`default_nettype wire

// File: tb/tbTisNode.sv
`timescale 1ns/1ns
`default_nettype none
`include "tis_consts.svh"

module tbTisNode;
   import tisIsaPkg::*;
   import tisPortPkg::*;

   localparam int nProg = 5;   // Idle plus four programs

   typedef struct packed {
      logic [`PC_W-1:0]          pc;
      logic signed [`DATA_W-1:0] acc;
      logic signed [`DATA_W-1:0] bak;
      logic signed [`DATA_W-1:0] out;
      logic [3:0]                read;
      logic [3:0]                write;
   } mdlS;

   logic                      clk;
   logic                      rst;
   logic                      progWe;
   logic [`PC_W-1:0]          progAddr;
   instrU                     progData;
   logic [`PC_W-1:0]          pLength;
   nbrInS                     nbr [4];
   logic [3:0]                wready;
   logic [3:0]                read;
   logic [3:0]                write;
   logic signed [`DATA_W-1:0] out;
   logic [`PC_W-1:0]          pc;
   logic signed [`DATA_W-1:0] acc;
   logic signed [`DATA_W-1:0] bak;

   logic [19:0] lfsr;
   instrU       prog [16];   // Model copy of the loaded program
   instrU       code [$];
   mdlS         mdl;

   tisNode u_dut (
      .clk      (clk),
      .rst      (rst),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .pLength  (pLength),
      .nbrIn    (nbr),
      .wready   (wready),
      .read     (read),
      .write    (write),
      .out      (out),
      .pc       (pc),
      .acc      (acc),
      .bak      (bak)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Taps x^20 + x^17 + 1 stepped once per bit
   function automatic logic [15:0] randBits(int n);
      logic [15:0] r;
      logic        fb;
      r = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[19] ^ lfsr[16];
         lfsr = {lfsr[18:0], fb};
         r    = {r[14:0], fb};
      end
      return r;
   endfunction

   function automatic instrU movI(logic [10:0] src, logic [2:0] dst);
      instrU w;
      w = {2'b00, dst, src};
      return w;
   endfunction

   function automatic instrU aluI(logic [2:0] grp, logic [10:0] src);
      instrU w;
      w = {2'b01, grp, src};
      return w;
   endfunction

   function automatic instrU jmpI(logic [6:0] sub, logic [3:0] t);
      instrU w;
      w = {2'b01, 3'd7, sub, t};
      return w;
   endfunction

   function automatic instrU miscI(logic [3:0] sel);
      return jmpI(subMisc, sel);
   endfunction

   function automatic logic signed [`DATA_W-1:0] sat(int x);
      if (x > `SAT_MAX) begin
         return `DATA_W'(`SAT_MAX);
      end else if (x < -`SAT_MAX) begin
         return `DATA_W'(-`SAT_MAX);
      end
      return `DATA_W'(x);
   endfunction

   // Reference model for one clock edge
   function automatic mdlS stepModel(mdlS s, instrU i, logic [3:0] len, nbrInS [3:0] nb,
                                     logic [3:0] wr);
      mdlS        n;
      int         v;
      int         sum;
      int         last;
      logic [3:0] nextPc;
      logic       isPort;
      logic       usesSrc;
      logic [1:0] d;
      n      = s;
      n.read = '0;
      last   = int'(len) - 1;
      nextPc = (int'(s.pc) == last) ? 4'd0 : s.pc + 4'd1;
      if (s.write != '0) begin
         if ((s.write & wr) != '0) begin
            n.write = '0;
            if (len != '0) begin
               n.pc = nextPc;
            end
         end
         return n;
      end
      if (len == '0) begin
         return n;
      end
      v      = $signed(i.op.operand);
      d      = i.op.operand[1:0];
      isPort = 1'b0;
      if (v > `SAT_MAX) begin
         if (v == int'(`SRC_ACC)) begin
            v = s.acc;
         end else if (v >= int'(`SRC_LEFT) && v <= int'(`SRC_DOWN)) begin
            isPort = 1'b1;
         end else begin
            v = 0;   // NIL, ANY and LAST codes
         end
      end
      usesSrc = !i.op.ctrl || (i.ctl.grp inside {opAdd, opSub, opJro});
      if (usesSrc && isPort) begin
         if (!nb[d].ready || s.read[d]) begin
            return n;   // Stall for the neighbor
         end
         v         = nb[d].data;
         n.read[d] = 1'b1;
      end
      n.pc = nextPc;
      if (!i.op.ctrl) begin
         case (i.op.dst)
            dirAcc: n.acc = `DATA_W'(v);
            dirLeft, dirRight, dirUp, dirDown: begin
               n.write = 4'b0001 << i.op.dst[1:0];
               n.out   = `DATA_W'(v);
               n.pc    = s.pc;
            end
            default: ;
         endcase
      end else begin
         case (i.ctl.grp)
            opAdd: n.acc = sat(int'(s.acc) + v);
            opSub: n.acc = sat(int'(s.acc) - v);
            opJro: begin
               sum = int'(s.pc) + v;
               if (sum < 0) begin
                  n.pc = '0;
               end else if (sum > last) begin
                  n.pc = 4'(last);
               end else begin
                  n.pc = 4'(sum);
               end
            end
            opMisc: begin
               case (i.ctl.subOp)
                  subJmp: n.pc = i.ctl.target;
                  subJez: if (s.acc == 0) n.pc = i.ctl.target;
                  subJnz: if (s.acc != 0) n.pc = i.ctl.target;
                  subJgz: if (s.acc > 0) n.pc = i.ctl.target;
                  subJlz: if (s.acc < 0) n.pc = i.ctl.target;
                  subMisc: begin
                     case (i.ctl.target)
                        miscSwp: begin
                           n.acc = s.bak;
                           n.bak = s.acc;
                        end
                        miscSav: n.bak = s.acc;
                        miscNeg: n.acc = sat(-int'(s.acc));
                        default: ;
                     endcase
                  end
                  default: ;
               endcase
            end
            default: ;
         endcase
      end
      return n;
   endfunction

   task automatic checkValue(string name, logic [15:0] got, logic [15:0] exp);
      assert (got === exp) else begin
         $display("Mismatch %s: dut %h, expected %h", name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "stopped at first error");
      end
   endtask

   // Outputs are stable at the falling edge
   always @(negedge clk) begin : compare
      nbrInS [3:0] nbPk;
      if (rst !== 1'b0) begin
         mdl = '0;
      end else begin
         checkValue("pc", 16'(pc), 16'(mdl.pc));
         checkValue("acc", 16'(acc), 16'(mdl.acc));
         checkValue("bak", 16'(bak), 16'(mdl.bak));
         checkValue("read", 16'(read), 16'(mdl.read));
         checkValue("write", 16'(write), 16'(mdl.write));
         checkValue("out", 16'(out), 16'(mdl.out));
         for (int d = 0; d < 4; d++) begin
            nbPk[d] = nbr[d];
         end
         mdl = stepModel(mdl, prog[mdl.pc], pLength, nbPk, wready);
      end
   end

   initial begin
      #(nProg * 400 * 10);
      $display("Watchdog expired before the tests finished");
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
   end

   // Neighbors retire a word under its read pulse
   task automatic driveCycle();
      logic [15:0] r;
      @(posedge clk);
      #1;
      for (int d = 0; d < 4; d++) begin
         if (read[d] || !nbr[d].ready) begin
            r           = randBits(12);
            nbr[d].ready = r[11];
            nbr[d].data  = r[10:0];
         end
      end
      r      = randBits(4);
      wready = r[3:0];
   endtask

   task automatic runCycles(int n);
      repeat (n) driveCycle();
   endtask

   task automatic applyReset();
      @(posedge clk);
      #1;
      rst     = 1'b1;
      pLength = '0;
      for (int i = 0; i < 16; i++) begin
         prog[i] = miscI(miscNop);
      end
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
   endtask

   task automatic runProgram(int cycles);
      applyReset();
      foreach (code[i]) begin
         @(posedge clk);
         #1;
         progWe   = 1'b1;
         progAddr = 4'(i);
         progData = code[i];
         prog[i]  = code[i];
      end
      @(posedge clk);
      #1;
      progWe  = 1'b0;
      pLength = 4'(code.size());
      runCycles(cycles);
      pLength = '0;   // State must hold from here
      runCycles(10);
   endtask

   initial begin
      rst      = 1'b1;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      pLength  = '0;
      wready   = '0;
      lfsr     = 20'd78696;
      for (int d = 0; d < 4; d++) begin
         nbr[d] = '0;
      end
      for (int i = 0; i < 16; i++) begin
         prog[i] = miscI(miscNop);
      end
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      runCycles(20);

      // Literals, saturation, SAV, SWP and NEG
      code.delete();
      code.push_back(movI(11'd900, dirAcc));
      code.push_back(aluI(opAdd, 11'd500));
      code.push_back(miscI(miscSav));
      code.push_back(movI(11'(-800), dirAcc));
      code.push_back(aluI(opSub, 11'd700));
      code.push_back(aluI(opAdd, `SRC_ACC));
      code.push_back(miscI(miscSwp));
      code.push_back(aluI(opAdd, `SRC_ACC));
      code.push_back(aluI(opSub, `SRC_ACC));
      code.push_back(aluI(opAdd, 11'd321));
      code.push_back(miscI(miscNeg));
      code.push_back(aluI(opAdd, `SRC_NIL));
      runProgram(300);

      // Jumps and the JRO clamp at both ends
      code.delete();
      code.push_back(movI(11'd1, dirAcc));
      code.push_back(jmpI(subJgz, 4'd3));
      code.push_back(aluI(opJro, 11'(-30)));
      code.push_back(jmpI(subJlz, 4'd0));
      code.push_back(jmpI(subJez, 4'd0));
      code.push_back(aluI(opSub, 11'd1));
      code.push_back(jmpI(subJgz, 4'd0));
      code.push_back(jmpI(subJnz, 4'd0));
      code.push_back(jmpI(subJez, 4'd10));
      code.push_back(aluI(opJro, 11'd20));
      code.push_back(aluI(opSub, 11'd1));
      code.push_back(jmpI(subJlz, 4'd13));
      code.push_back(miscI(miscNop));
      code.push_back(jmpI(subJnz, 4'd9));
      code.push_back(jmpI(subJmp, 4'd2));
      runProgram(300);

      // Port reads
      code.delete();
      code.push_back(movI(`SRC_LEFT, dirAcc));
      code.push_back(aluI(opAdd, `SRC_RIGHT));
      code.push_back(aluI(opSub, `SRC_UP));
      code.push_back(movI(`SRC_DOWN, dirNil));
      code.push_back(movI(`SRC_DOWN, dirAcc));
      code.push_back(aluI(opAdd, `SRC_UP));
      runProgram(300);

      // Port writes, old ANY and LAST codes
      code.delete();
      code.push_back(movI(`SRC_LEFT, dirRight));
      code.push_back(movI(`SRC_ACC, dirUp));
      code.push_back(movI(11'd5, dirDown));
      code.push_back(movI(11'd7, 3'd2));
      code.push_back(movI(11'd9, 3'd3));
      code.push_back(aluI(opAdd, 11'd1));
      code.push_back(movI(`SRC_RIGHT, dirLeft));
      code.push_back(movI(`SRC_DOWN, dirAcc));
      runProgram(300);

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/tisIsaPkg.sv
logic/tisPortPkg.sv
logic/progMem.sv
logic/satAlu.sv
logic/portUnit.sv
logic/nodeSequencer.sv
logic/tisNode.sv
tb/tbTisNode.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tbTisNode
FILELIST  := sources.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
